// ==== include/mc_params.svh ====
// ==============================
// Widths and depths of the matrix engine
// Included by the packages and by any module that sizes a vector
// ==============================
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// Element width, values fold modulo 2^31-1
`define MC_DATA_W 31
// Store address and depth, up to 16x16 elements
`define MC_ADDR_W 8
`define MC_DEPTH 256
// Element counter must reach 256
`define MC_CNT_W 9
// Side length must reach 16
`define MC_SIDE_W 5

`endif

// ==== mc.f ====
+incdir+include
src/mc_cmd_pkg.sv
src/mc_mem_pkg.sv
src/mc_matrix_ram.sv
src/mc_mod_adder.sv
src/mc_reorder_addr.sv
src/mc_ctrl.sv
src/mc_out_stage.sv
src/mc_top.sv
tb/mc_props.sv
tb/mc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the matrix engine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mc_tb -f mc.f

# Result taken from the pass line in the output
out=$(./obj_dir/Vmc_tb 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== src/mc_cmd_pkg.sv ====
// ==============================
// Command and controller phase encodings
// Imported by the controller, index generator and top level
// ==============================
package mc_cmd_pkg;

	// Command codes as seen on action_i
	// Codes 2, 6 and 7 are not accepted
	typedef enum logic [2:0] {
		OP_LOAD   = 3'd0,
		OP_ADD    = 3'd1,
		OP_TRANS  = 3'd3,
		OP_MIRROR = 3'd4,
		OP_ROTATE = 3'd5
	} mc_op_e;

	// Controller phases
	typedef enum logic [2:0] {
		PH_IDLE, PH_FILL, PH_FOLD, PH_STORE,
		PH_TO_T, PH_SETTLE, PH_TO_C, PH_OUT
	} mc_phase_e;

endpackage

// ==== src/mc_ctrl.sv ====
// ==============================
// Command FSM of the matrix engine
// Drives the C, M and T stores, the adder and the output handover
// ==============================
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid_i,
	input  mc_mem_pkg::mc_elem_t in_data_i,
	input  logic [2:0]           action_i,
	input  logic [1:0]           size_code_i,
	input  mc_mem_pkg::mc_elem_t c_rdata_i,
	input  mc_mem_pkg::mc_elem_t t_rdata_i,
	input  mc_mem_pkg::mc_elem_t sum_i,
	input  logic                 settled_i,
	input  mc_mem_pkg::mc_addr_t t_addr_i,
	input  logic                 out_done_i,
	output logic                 c_we_o,
	output logic                 m_we_o,
	output logic                 t_we_o,
	output mc_mem_pkg::mc_addr_t c_addr_o,
	output mc_mem_pkg::mc_addr_t m_addr_o,
	output mc_mem_pkg::mc_addr_t t_addr_o,
	output mc_mem_pkg::mc_elem_t c_wdata_o,
	output mc_mem_pkg::mc_elem_t t_wdata_o,
	output logic                 fold_en_o,
	output mc_mem_pkg::mc_cnt_t  cnt_o,
	output mc_mem_pkg::mc_side_t side_o,
	output mc_cmd_pkg::mc_op_e   op_o,
	output logic                 out_start_o,
	output logic                 out_burst_o
);
	import mc_cmd_pkg::*;
	import mc_mem_pkg::*;

	mc_phase_e phase_q;
	mc_op_e    op_q;
	mc_op_e    act_op;
	mc_cnt_t   cnt_q;
	mc_side_t  side_q;
	mc_side_t  side_dec;
	mc_cnt_t   side_ext;
	mc_cnt_t   elem_cnt;
	mc_cnt_t   elem_last;
	logic      cmd_ok;
	logic      out_start_q;

	// Decode of the incoming command
	assign act_op = mc_op_e'(action_i);
	assign cmd_ok = in_valid_i
		&& (act_op inside {OP_LOAD, OP_ADD, OP_TRANS, OP_MIRROR, OP_ROTATE});

	always_comb begin
		case (size_code_i)
			2'd0:    side_dec = 5'd2;
			2'd1:    side_dec = 5'd4;
			2'd2:    side_dec = 5'd8;
			default: side_dec = 5'd16;
		endcase
	end

	// N*N and its last index
	assign side_ext  = {{(`MC_CNT_W-`MC_SIDE_W){1'b0}}, side_q};
	assign elem_cnt  = side_ext * side_ext;
	assign elem_last = elem_cnt - 1'b1;

	// ==============================
	// Phase, counter and latches
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q     <= PH_IDLE;
			op_q        <= OP_LOAD;
			cnt_q       <= '0;
			side_q      <= '0;
			out_start_q <= 1'b0;
		end else begin
			out_start_q <= 1'b0;
			case (phase_q)
				PH_IDLE: begin
					cnt_q <= '0;
					if (cmd_ok) begin
						op_q <= act_op;
						// Size only taken with a load
						if (act_op == OP_LOAD) begin
							side_q <= side_dec;
						end
						// First element written this cycle
						if (act_op == OP_LOAD || act_op == OP_ADD) begin
							cnt_q   <= 9'd1;
							phase_q <= PH_FILL;
						end else begin
							phase_q <= PH_TO_T;
						end
					end
				end
				PH_FILL: begin
					// Stream in, wrap to 0 for the add walk
					if (in_valid_i) begin
						cnt_q <= (cnt_q == elem_last) ? '0 : cnt_q + 1'b1;
					end else if (op_q == OP_ADD) begin
						phase_q <= PH_FOLD;
					end else begin
						phase_q     <= PH_OUT;
						out_start_q <= 1'b1;
					end
				end
				PH_FOLD: begin
					if (settled_i) begin
						phase_q <= PH_STORE;
					end
				end
				PH_STORE: begin
					if (cnt_q == elem_last) begin
						cnt_q       <= '0;
						phase_q     <= PH_OUT;
						out_start_q <= 1'b1;
					end else begin
						cnt_q   <= cnt_q + 1'b1;
						phase_q <= PH_FILL;
					end
				end
				PH_TO_T: begin
					if (cnt_q == elem_last) begin
						cnt_q   <= '0;
						phase_q <= PH_SETTLE;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				// Last T write lands here
				PH_SETTLE: phase_q <= PH_TO_C;
				PH_TO_C: begin
					// One extra count for the read latency
					if (cnt_q == elem_cnt) begin
						cnt_q       <= '0;
						phase_q     <= PH_OUT;
						out_start_q <= 1'b1;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				PH_OUT: begin
					if (out_done_i) begin
						phase_q <= PH_IDLE;
					end
				end
				default: phase_q <= PH_IDLE;
			endcase
		end
	end

	// ==============================
	// Store controls
	// ==============================
	always_comb begin
		c_we_o    = 1'b0;
		m_we_o    = 1'b0;
		t_we_o    = 1'b0;
		fold_en_o = 1'b0;
		c_addr_o  = cnt_q[`MC_ADDR_W-1:0];
		t_addr_o  = t_addr_i;
		c_wdata_o = in_data_i;
		case (phase_q)
			PH_IDLE: begin
				c_we_o = in_valid_i && (act_op == OP_LOAD);
				m_we_o = in_valid_i && (act_op == OP_ADD);
			end
			PH_FILL: begin
				c_we_o = in_valid_i && (op_q == OP_LOAD);
				m_we_o = in_valid_i && (op_q == OP_ADD);
			end
			PH_FOLD:  fold_en_o = 1'b1;
			PH_STORE: begin
				c_we_o    = 1'b1;
				c_wdata_o = sum_i;
			end
			// C data and permuted index trail the counter by one
			PH_TO_T:   t_we_o = (cnt_q != '0);
			PH_SETTLE: t_we_o = 1'b1;
			PH_TO_C: begin
				c_we_o    = (cnt_q != '0);
				c_addr_o  = cnt_q[`MC_ADDR_W-1:0] - 1'b1;
				c_wdata_o = t_rdata_i;
				t_addr_o  = cnt_q[`MC_ADDR_W-1:0];
			end
			default: ;
		endcase
	end

	assign m_addr_o    = cnt_q[`MC_ADDR_W-1:0];
	assign t_wdata_o   = c_rdata_i;
	assign cnt_o       = cnt_q;
	assign side_o      = side_q;
	assign op_o        = op_q;
	assign out_start_o = out_start_q;
	// Load and add echo the whole matrix
	assign out_burst_o = (op_q == OP_LOAD) || (op_q == OP_ADD);

endmodule

// ==== src/mc_matrix_ram.sv ====
// ==============================
// Single-port matrix store, 256 words
// Registered read, data one cycle after address
// ==============================
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_matrix_ram (
	input  logic                 clk,
	input  logic                 we_i,
	input  mc_mem_pkg::mc_addr_t addr_i,
	input  mc_mem_pkg::mc_elem_t wdata_i,
	output mc_mem_pkg::mc_elem_t rdata_o
);
	import mc_mem_pkg::*;

	// Storage array
	mc_elem_t mem_q [`MC_DEPTH];

	// Write on enable
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem_q[addr_i] <= wdata_i;
		end
	end

	// Read every cycle
	// old word returned on a same-address write
	always_ff @(posedge clk) begin
		rdata_o <= mem_q[addr_i];
	end

endmodule

// ==== src/mc_mem_pkg.sv ====
// ==============================
// Data, address and count types for the matrix stores
// ==============================
`include "mc_params.svh"

package mc_mem_pkg;

	// One matrix element
	typedef logic [`MC_DATA_W-1:0] mc_elem_t;
	// Row-major word address
	typedef logic [`MC_ADDR_W-1:0] mc_addr_t;
	// Element count, 0 to 256
	typedef logic [`MC_CNT_W-1:0]  mc_cnt_t;
	// Side length N
	typedef logic [`MC_SIDE_W-1:0] mc_side_t;

endpackage

// ==== src/mc_mod_adder.sv ====
// ==============================
// Adder folding modulo 2^31-1
// Hold fold_en_i high until settled_o, then read sum_o
// ==============================
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_mod_adder (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fold_en_i,
	input  mc_mem_pkg::mc_elem_t a_i,
	input  mc_mem_pkg::mc_elem_t b_i,
	output mc_mem_pkg::mc_elem_t sum_o,
	output logic                 settled_o
);
	// Fold register, top bit is the carry
	logic [`MC_DATA_W:0] acc_q;
	// Enable seen last cycle
	logic                first_q;
	logic                settled_q;

	// Control state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_q   <= 1'b0;
			settled_q <= 1'b0;
		end else begin
			first_q   <= fold_en_i;
			// Carry gone, value is final
			settled_q <= fold_en_i && first_q && !acc_q[`MC_DATA_W];
		end
	end

	// First cycle takes the exact sum
	// later cycles add the carry back into the low bits
	always_ff @(posedge clk) begin
		if (fold_en_i) begin
			if (!first_q) begin
				acc_q <= {1'b0, a_i} + {1'b0, b_i};
			end else begin
				acc_q <= {1'b0, acc_q[`MC_DATA_W-1:0]}
					+ {{`MC_DATA_W{1'b0}}, acc_q[`MC_DATA_W]};
			end
		end
	end

	assign sum_o     = acc_q[`MC_DATA_W-1:0];
	assign settled_o = settled_q;

endmodule

// ==== src/mc_out_stage.sv ====
// ==============================
// Output sequencer
// Burst mode reads C in row-major order, else one zero pulse
// ==============================
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_out_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 out_start_i,
	input  logic                 out_burst_i,
	input  mc_mem_pkg::mc_side_t side_i,
	input  mc_mem_pkg::mc_elem_t c_rdata_i,
	output mc_mem_pkg::mc_addr_t c_raddr_o,
	output logic                 out_valid_o,
	output mc_mem_pkg::mc_elem_t out_data_o,
	output logic                 out_done_o
);
	import mc_mem_pkg::*;

	mc_cnt_t side_ext;
	mc_cnt_t elem_last;
	mc_cnt_t rd_cnt_q;
	// Reads still being issued
	logic    busy_q;
	// Read issued last cycle, and whether it was the final one
	logic    rd_valid_q;
	logic    rd_last_q;
	logic    single;

	assign side_ext  = {{(`MC_CNT_W-`MC_SIDE_W){1'b0}}, side_i};
	assign elem_last = side_ext * side_ext - 1'b1;
	assign single    = out_start_i && !out_burst_i;

	// Read address walk
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q     <= 1'b0;
			rd_cnt_q   <= '0;
			rd_valid_q <= 1'b0;
			rd_last_q  <= 1'b0;
		end else begin
			rd_valid_q <= busy_q;
			rd_last_q  <= busy_q && (rd_cnt_q == elem_last);
			if (out_start_i && out_burst_i) begin
				busy_q   <= 1'b1;
				rd_cnt_q <= '0;
			end else if (busy_q) begin
				if (rd_cnt_q == elem_last) begin
					busy_q <= 1'b0;
				end else begin
					rd_cnt_q <= rd_cnt_q + 1'b1;
				end
			end
		end
	end

	// Output register, done rides with the last valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid_o <= 1'b0;
			out_data_o  <= '0;
			out_done_o  <= 1'b0;
		end else begin
			out_valid_o <= rd_valid_q || single;
			out_data_o  <= rd_valid_q ? c_rdata_i : '0;
			out_done_o  <= (rd_valid_q && rd_last_q) || single;
		end
	end

	assign c_raddr_o = rd_cnt_q[`MC_ADDR_W-1:0];

endmodule

// ==== src/mc_reorder_addr.sv ====
// ==============================
// Destination index for transpose, mirror and rotate
// Address follows the counter by one cycle
// ==============================
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_reorder_addr (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mc_mem_pkg::mc_cnt_t  cnt_i,
	input  mc_mem_pkg::mc_side_t side_i,
	input  mc_cmd_pkg::mc_op_e   op_i,
	output mc_mem_pkg::mc_addr_t t_addr_o
);
	import mc_cmd_pkg::*;
	import mc_mem_pkg::*;

	logic [2:0] shift;
	mc_addr_t   idx;
	mc_addr_t   row;
	mc_addr_t   col;
	// N-1
	mc_addr_t   top_idx;
	mc_addr_t   dst_row;
	mc_addr_t   dst_col;

	// N is a power of two, divide by shifting
	always_comb begin
		case (side_i)
			5'd2:    shift = 3'd1;
			5'd4:    shift = 3'd2;
			5'd8:    shift = 3'd3;
			default: shift = 3'd4;
		endcase
	end

	// Source row and column
	assign idx     = cnt_i[`MC_ADDR_W-1:0];
	assign top_idx = mc_addr_t'(side_i) - 1'b1;
	assign row     = idx >> shift;
	assign col     = idx & top_idx;

	// Where old (row, col) lands
	always_comb begin
		case (op_i)
			OP_TRANS: begin
				dst_row = col;
				dst_col = row;
			end
			OP_MIRROR: begin
				dst_row = row;
				dst_col = top_idx - col;
			end
			OP_ROTATE: begin
				dst_row = top_idx - col;
				dst_col = row;
			end
			default: begin
				dst_row = row;
				dst_col = col;
			end
		endcase
	end

	// Row-major destination
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			t_addr_o <= '0;
		end else begin
			t_addr_o <= (dst_row << shift) | dst_col;
		end
	end

endmodule

// ==== src/mc_top.sv ====
// ==============================
// Matrix engine top level
// Controller, three stores, adder, index generator and output stage
// ==============================
`timescale 1ns/1ps

module mc_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid_i,
	input  mc_mem_pkg::mc_elem_t in_data_i,
	input  logic [2:0]           action_i,
	input  logic [1:0]           size_code_i,
	output logic                 out_valid_o,
	output mc_mem_pkg::mc_elem_t out_data_o
);
	import mc_cmd_pkg::*;
	import mc_mem_pkg::*;

	// Store buses
	mc_elem_t c_rdata, m_rdata, t_rdata;
	mc_elem_t c_wdata, t_wdata;
	mc_addr_t c_addr, ctrl_c_addr, out_c_addr;
	mc_addr_t m_addr, t_addr, gen_t_addr;
	logic     c_we, m_we, t_we;
	// Adder and control
	mc_elem_t sum;
	logic     fold_en, settled;
	mc_cnt_t  cnt;
	mc_side_t side;
	mc_op_e   op;
	logic     out_start, out_burst, out_done;
	// Output stage owns C's address
	logic     out_own_q;

	mc_ctrl u_ctrl (
		.clk, .rst_n, .in_valid_i, .in_data_i, .action_i, .size_code_i,
		.c_rdata_i(c_rdata), .t_rdata_i(t_rdata), .sum_i(sum), .settled_i(settled),
		.t_addr_i(gen_t_addr), .out_done_i(out_done),
		.c_we_o(c_we), .m_we_o(m_we), .t_we_o(t_we),
		.c_addr_o(ctrl_c_addr), .m_addr_o(m_addr), .t_addr_o(t_addr),
		.c_wdata_o(c_wdata), .t_wdata_o(t_wdata), .fold_en_o(fold_en),
		.cnt_o(cnt), .side_o(side), .op_o(op),
		.out_start_o(out_start), .out_burst_o(out_burst)
	);

	// Ownership from start to done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_own_q <= 1'b0;
		end else if (out_start) begin
			out_own_q <= 1'b1;
		end else if (out_done) begin
			out_own_q <= 1'b0;
		end
	end

	assign c_addr = out_own_q ? out_c_addr : ctrl_c_addr;

	mc_matrix_ram u_c_ram (.clk, .we_i(c_we), .addr_i(c_addr), .wdata_i(c_wdata), .rdata_o(c_rdata));
	// M only ever takes input data
	mc_matrix_ram u_m_ram (.clk, .we_i(m_we), .addr_i(m_addr), .wdata_i(in_data_i), .rdata_o(m_rdata));
	mc_matrix_ram u_t_ram (.clk, .we_i(t_we), .addr_i(t_addr), .wdata_i(t_wdata), .rdata_o(t_rdata));

	mc_mod_adder u_adder (
		.clk, .rst_n, .fold_en_i(fold_en), .a_i(c_rdata), .b_i(m_rdata),
		.sum_o(sum), .settled_o(settled)
	);

	mc_reorder_addr u_reorder (
		.clk, .rst_n, .cnt_i(cnt), .side_i(side), .op_i(op), .t_addr_o(gen_t_addr)
	);

	mc_out_stage u_out (
		.clk, .rst_n, .out_start_i(out_start), .out_burst_i(out_burst), .side_i(side),
		.c_rdata_i(c_rdata), .c_raddr_o(out_c_addr),
		.out_valid_o, .out_data_o, .out_done_o(out_done)
	);

endmodule

// ==== tb/mc_props.sv ====
// ==============================
// Port checks for the matrix engine
// Bound to mc_top by the testbench
// ==============================
`timescale 1ns/1ps

module mc_props (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 in_valid_i,
	input logic                 out_valid_o,
	input mc_mem_pkg::mc_elem_t out_data_o
);

	// Data bus quiet between beats
	a_data_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid_o |-> (out_data_o == '0))
		else $error("out_data_o nonzero while out_valid_o is low");

	// Output never overlaps an input burst
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid_i |-> !out_valid_o)
		else $error("out_valid_o high while in_valid_i is high");

	// Outputs held at zero in reset
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> (!out_valid_o && out_data_o == '0))
		else $error("outputs not zero during reset");

endmodule

// ==== tb/mc_tb.sv ====
// ==============================
// Testbench for the matrix engine
// Load, add, reorder and ignored commands checked against a model of C
// ==============================
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_tb;
	import mc_cmd_pkg::*;
	import mc_mem_pkg::*;

	localparam int CLK_PERIOD = 100;
	// Elements moved per test: loads, adds, reorder passes, ignored codes
	localparam int TEST_ELEMS = (4 + 16 + 64 + 256) + (2 * 64 + 2 * 16) + 3 * 64
		+ 8 * 64 + (3 + 64);
	localparam int WATCHDOG_CYCLES = TEST_ELEMS * 40 + 200;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     in_valid_i;
	mc_elem_t in_data_i;
	logic [2:0] action_i;
	logic [1:0] size_code_i;
	logic     out_valid_o;
	mc_elem_t out_data_o;

	// Model of C, next stimulus, saved copy
	mc_elem_t model_c [`MC_DEPTH];
	mc_elem_t stim [`MC_DEPTH];
	mc_elem_t orig_c [`MC_DEPTH];
	// Beats still owed by the DUT
	mc_elem_t exp_q [$];
	int side_n = 2;
	int errors = 0;
	int checks = 0;
	int test_num = 0;
	int errs_at_start = 0;
	logic prev_valid = 1'b0;
	int unsigned seed_init;

	mc_top i_mc_top (
		.clk, .rst_n, .in_valid_i, .in_data_i, .action_i, .size_code_i,
		.out_valid_o, .out_data_o
	);

	bind mc_top mc_props u_props (.clk, .rst_n, .in_valid_i, .out_valid_o, .out_data_o);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==============================
	// Reference rules
	// ==============================
	// Exact sum, folded once past 2^31
	function automatic mc_elem_t fold_sum(input mc_elem_t a, input mc_elem_t b);
		logic [31:0] s;
		s = {1'b0, a} + {1'b0, b};
		if (s >= 32'h8000_0000) begin
			s = s - 32'h8000_0000 + 32'd1;
		end
		return s[30:0];
	endfunction

	// Old index that lands at new (r, c)
	function automatic int reorder_src(input mc_op_e op, input int r, input int c,
		input int n);
		case (op)
			OP_TRANS:  return c * n + r;
			OP_MIRROR: return r * n + (n - 1 - c);
			// Rotate
			default:   return c * n + (n - 1 - r);
		endcase
	endfunction

	// ==============================
	// Stimulus tasks
	// ==============================
	task automatic fill_random(input int n);
		for (int k = 0; k < n * n; k++) begin
			stim[k] = mc_elem_t'($urandom());
		end
	endtask

	task automatic fill_zero();
		for (int k = 0; k < `MC_DEPTH; k++) begin
			stim[k] = '0;
		end
	endtask

	// One element per cycle, inputs change on the falling edge
	task automatic drive_burst(input logic [2:0] op, input logic [1:0] code, input int count);
		for (int k = 0; k < count; k++) begin
			@(negedge clk);
			in_valid_i  = 1'b1;
			action_i    = op;
			size_code_i = code;
			in_data_i   = stim[k];
		end
		@(negedge clk);
		in_valid_i = 1'b0;
		in_data_i  = '0;
	endtask

	// Until every owed beat is seen, then let the FSM reach idle
	task automatic wait_output();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (3) @(negedge clk);
	endtask

	task automatic load_matrix(input int code);
		side_n = 2 << code;
		for (int k = 0; k < side_n * side_n; k++) begin
			model_c[k] = stim[k];
			exp_q.push_back(model_c[k]);
		end
		drive_burst(OP_LOAD, code[1:0], side_n * side_n);
		wait_output();
	endtask

	task automatic add_matrix();
		for (int k = 0; k < side_n * side_n; k++) begin
			model_c[k] = fold_sum(model_c[k], stim[k]);
			exp_q.push_back(model_c[k]);
		end
		drive_burst(OP_ADD, 2'd0, side_n * side_n);
		wait_output();
	endtask

	// Single zero pulse, model permuted
	task automatic reorder_matrix(input mc_op_e op);
		mc_elem_t old_c [`MC_DEPTH];
		old_c = model_c;
		for (int r = 0; r < side_n; r++) begin
			for (int c = 0; c < side_n; c++) begin
				model_c[r * side_n + c] = old_c[reorder_src(op, r, c, side_n)];
			end
		end
		exp_q.push_back('0);
		drive_burst(op, 2'd0, 1);
		wait_output();
	endtask

	// No beat owed, any output is caught by the compare
	task automatic send_ignored(input logic [2:0] code);
		drive_burst(code, 2'd0, 1);
		repeat (20) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		test_num++;
		if (errors == errs_at_start) begin
			$display("test %0d, %s: ok", test_num, name);
		end else begin
			$display("test %0d, %s: %0d errors", test_num, name, errors - errs_at_start);
		end
		errs_at_start = errors;
	endtask

	// ==============================
	// Output compare
	// ==============================
	always @(negedge clk) begin : compare_beats
		mc_elem_t exp_val;
		if (rst_n) begin
			if (out_valid_o) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected out_valid_o beat at %0t with no output owed", $time);
				end else begin
					exp_val = exp_q.pop_front();
					checks++;
					if (out_data_o !== exp_val) begin
						errors++;
						$display("mismatch at %0t: out_data_o got %h, expected %h",
							$time, out_data_o, exp_val);
					end
				end
			end else if (prev_valid && exp_q.size() != 0) begin
				errors++;
				$display("out_valid_o dropped at %0t with %0d beats of the burst missing",
					$time, exp_q.size());
			end
			prev_valid = out_valid_o;
		end
	end

	// Hard stop if the DUT goes quiet
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, DUT stopped answering", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		rst_n       = 1'b1;
		in_valid_i  = 1'b0;
		in_data_i   = '0;
		action_i    = '0;
		size_code_i = '0;
		seed_init   = $urandom(84);
		#10;
		rst_n = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);

		// Echo at every size
		for (int code = 0; code < 4; code++) begin
			fill_random(2 << code);
			load_matrix(code);
		end
		finish_test("load echo");

		// Random add, then forced folds and exact maximum sums
		fill_random(8);
		load_matrix(2);
		fill_random(8);
		add_matrix();
		fill_random(4);
		for (int k = 0; k < 8; k++) begin
			stim[k] = mc_elem_t'(32'h7FFF_FFF0 + k);
		end
		load_matrix(1);
		for (int k = 0; k < 16; k++) begin
			if (k < 8) begin
				stim[k] = mc_elem_t'(32'h7FFF_FF00 + k);
			end else begin
				stim[k] = 31'h7FFF_FFFF - model_c[k];
			end
		end
		add_matrix();
		finish_test("modulo add");

		// Transpose shown by a zero add
		fill_random(8);
		load_matrix(2);
		reorder_matrix(OP_TRANS);
		fill_zero();
		add_matrix();
		finish_test("transpose");

		// Mirror, rotate, then four rotations back to the start
		reorder_matrix(OP_MIRROR);
		fill_zero();
		add_matrix();
		orig_c = model_c;
		reorder_matrix(OP_ROTATE);
		fill_zero();
		add_matrix();
		repeat (3) reorder_matrix(OP_ROTATE);
		fill_zero();
		for (int k = 0; k < side_n * side_n; k++) begin
			exp_q.push_back(orig_c[k]);
		end
		drive_burst(OP_ADD, 2'd0, side_n * side_n);
		wait_output();
		finish_test("mirror and rotate");

		// Unused codes leave C alone
		send_ignored(3'd2);
		send_ignored(3'd6);
		send_ignored(3'd7);
		fill_zero();
		add_matrix();
		finish_test("ignored codes");

		$display("%0d tests run, %0d beats checked, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
